// ==== build.f ====
rtl/rvCorePkg.sv
rtl/alu.sv
rtl/instrFetch.sv
rtl/decode.sv
rtl/regFile.sv
rtl/execute.sv
rtl/rvCore.sv
bench/benchMemory.sv
bench/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvcore

sources:
  - rtl/rvCorePkg.sv
  - rtl/alu.sv
  - rtl/instrFetch.sv
  - rtl/decode.sv
  - rtl/regFile.sv
  - rtl/execute.sv
  - rtl/rvCore.sv
  - target: test
    files:
      - bench/benchMemory.sv
      - bench/rvCoreTb.sv

// ==== bench/rvCoreTb.sv ====
// RV32I core testbench
`timescale 1ns/1ps

module rvCoreTb;

    localparam logic [31:0] resetVector = 32'h0000_0100;
    // Address of the closing self loop
    localparam logic [31:0] endAddr = 32'h0000_01d4;
    localparam int wbCount   = 31;
    localparam int stCount   = 3;
    localparam int pcCount   = 47;
    localparam int maxCycles = 400;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        dataWrite;
    logic        dataRead;
    logic [31:0] dataRdata;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    // Hand-worked writeback trace as register and value pairs
    logic [36:0] expWb [wbCount] = '{
        {5'd1, 32'h1234_5000}, {5'd1, 32'h1234_5678}, {5'd2, 32'h0000_1108},
        {5'd3, 32'hffff_fffb}, {5'd4, 32'h0000_0007}, {5'd5, 32'h0000_0001},
        {5'd6, 32'h0000_0000}, {5'd7, 32'h0000_00f7}, {5'd8, 32'h0000_0107},
        {5'd9, 32'h0000_0078}, {5'd10, 32'h0000_0070}, {5'd11, 32'h0000_000f},
        {5'd12, 32'hffff_fffd}, {5'd13, 32'h0000_0002}, {5'd14, 32'h0000_000c},
        {5'd15, 32'h0000_0380}, {5'd16, 32'h0000_0001}, {5'd17, 32'h0000_0000},
        {5'd18, 32'hedcb_a983}, {5'd19, 32'h01ff_ffff}, {5'd20, 32'hffff_ffff},
        {5'd21, 32'h0000_0077}, {5'd22, 32'h0000_0070}, {5'd23, 32'h1234_5678},
        {5'd24, 32'hffff_fffb}, {5'd0, 32'h0000_0063}, {5'd25, 32'h0000_0000},
        {5'd27, 32'h0000_01c0}, {5'd29, 32'h0000_01cc}, {5'd28, 32'h0000_0044},
        {5'd0, 32'h0000_01c8}
    };

    // Expected stores as address and data pairs
    logic [63:0] expStore [stCount] = '{
        {32'h0000_0010, 32'h1234_5678},
        {32'h0000_0068, 32'hffff_fffb},
        {32'h0000_0018, 32'h0000_01cc}
    };

    // Fetch addresses through straight code then branches and jumps
    logic [31:0] expPc [pcCount] = '{
        32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114,
        32'h118, 32'h11c, 32'h120, 32'h124, 32'h128, 32'h12c,
        32'h130, 32'h134, 32'h138, 32'h13c, 32'h140, 32'h144,
        32'h148, 32'h14c, 32'h150, 32'h154, 32'h158, 32'h15c,
        32'h160, 32'h164, 32'h168, 32'h16c, 32'h170, 32'h174,
        32'h17c, 32'h180, 32'h188, 32'h18c, 32'h194, 32'h198,
        32'h1a0, 32'h1a4, 32'h1ac, 32'h1b0, 32'h1b8, 32'h1bc,
        32'h1c8, 32'h1c0, 32'h1c4, 32'h1d0, 32'h1d4
    };

    int   wbIdx = 0;
    int   stIdx = 0;
    int   pcIdx = 0;
    int   cycleCount = 0;
    logic prevWb;
    logic prevWr;
    logic prevRd;
    logic prevChanged;
    logic addrChanged;
    logic [31:0] prevAddr;

    rvCore #(
        .resetVector (resetVector)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWrite (dataWrite),
        .dataRead  (dataRead),
        .dataRdata (dataRdata),
        .wbValid   (wbValid),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    benchMemory #(
        .romBase (resetVector)
    ) u_mem (
        .clk       (clk),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWrite (dataWrite),
        .dataRead  (dataRead),
        .dataRdata (dataRdata)
    );

    always #50 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic valueMismatch(input string sigName, input logic [31:0] got,
                                 input logic [31:0] exp);
        abortRun($sformatf("ERR time=%0t %s got=%h expected=%h", $time, sigName, got, exp));
    endtask

    // PC at the vector and no strobe
    task automatic idleCheck(input string when);
        assert (instrAddr === resetVector)
        else valueMismatch("instrAddr", instrAddr, resetVector);
        assert (!dataWrite && !dataRead && !wbValid)
        else abortRun({"A strobe was active ", when});
    endtask

    task automatic fetchCheck();
        if (pcIdx >= pcCount)
            abortRun("More fetches than the expected PC sequence holds");
        else
        begin
            assert (instrAddr === expPc[pcIdx])
            else valueMismatch("instrAddr", instrAddr, expPc[pcIdx]);
            pcIdx++;
        end
    endtask

    task automatic writebackCheck();
        if (wbIdx >= wbCount)
            abortRun("A register write came after the expected sequence ended");
        else
        begin
            assert (wbReg === expWb[wbIdx][36:32])
            else valueMismatch("wbReg", {27'd0, wbReg}, {27'd0, expWb[wbIdx][36:32]});
            assert (wbData === expWb[wbIdx][31:0])
            else valueMismatch("wbData", wbData, expWb[wbIdx][31:0]);
            wbIdx++;
        end
    endtask

    task automatic storeCheck();
        if (stIdx >= stCount)
            abortRun("A store came after the expected sequence ended");
        else
        begin
            assert (dataAddr === expStore[stIdx][63:32])
            else valueMismatch("dataAddr", dataAddr, expStore[stIdx][63:32]);
            assert (dataWdata === expStore[stIdx][31:0])
            else valueMismatch("dataWdata", dataWdata, expStore[stIdx][31:0]);
            stIdx++;
        end
    endtask

    // Sampled mid cycle away from the driving edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            idleCheck("while reset was held");
            cycleCount  = 0;
            prevWb      = 1'b0;
            prevWr      = 1'b0;
            prevRd      = 1'b0;
            prevChanged = 1'b0;
            prevAddr    = instrAddr;
        end
        else
        begin
            if (cycleCount == 0)
                idleCheck("in the first cycle after reset");
            // Strobes last a single execute cycle
            assert (!(wbValid && prevWb))
            else abortRun("wbValid stayed high on two consecutive cycles");
            assert (!(dataWrite && prevWr))
            else abortRun("dataWrite stayed high on two consecutive cycles");
            assert (!(dataRead && prevRd))
            else abortRun("dataRead stayed high on two consecutive cycles");
            addrChanged = (instrAddr !== prevAddr);
            assert (!(addrChanged && prevChanged))
            else abortRun("instrAddr changed on two consecutive edges");
            // Even cycles are fetch
            if (cycleCount % 2 == 0)
                fetchCheck();
            if (wbValid)
                writebackCheck();
            if (dataWrite)
                storeCheck();
            prevWb      = wbValid;
            prevWr      = dataWrite;
            prevRd      = dataRead;
            prevChanged = addrChanged;
            prevAddr    = instrAddr;
            cycleCount++;
        end
    end

    initial
    begin
        int waitCycles;
        rst = 1'b1;
        waitCycles = 0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        // Run until the self loop is fetched
        while ((instrAddr !== endAddr) && (waitCycles < maxCycles))
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (instrAddr !== endAddr)
            abortRun("The program never reached its final self loop");
        else
        begin
            // Checker has sampled that fetch by now
            @(posedge clk);
            #1;
            if ((wbIdx == wbCount) && (stIdx == stCount) && (pcIdx == pcCount))
            begin
                $display("STATUS: PASS");
                $finish;
            end
            else
                abortRun($sformatf("Run ended early with %0d writes, %0d stores, %0d fetches",
                                   wbIdx, stIdx, pcIdx));
        end
    end

endmodule

// ==== bench/benchMemory.sv ====
// Bench instruction and data memory
`timescale 1ns/1ps

module benchMemory #(
    parameter logic [31:0] romBase = 32'h0000_0100
) (
    input  logic        clk,
    input  logic [31:0] instrAddr,
    output logic [31:0] instrData,
    input  logic [31:0] dataAddr,
    input  logic [31:0] dataWdata,
    input  logic        dataWrite,
    input  logic        dataRead,
    output logic [31:0] dataRdata
);

    // Major opcodes, from the ISA manual
    localparam logic [6:0] opcLui   = 7'b0110111;
    localparam logic [6:0] opcAuipc = 7'b0010111;
    localparam logic [6:0] opcJalr  = 7'b1100111;
    localparam logic [6:0] opcLoad  = 7'b0000011;
    localparam logic [6:0] opcImm   = 7'b0010011;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] romOffset;

    // Instruction assemblers, one per format
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Word store only
    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    initial
    begin
        // Empty slots stay zero, which the core treats as a no-op
        for (int i = 0; i < 64; i++)
        begin
            rom[i] = 32'd0;
            // Each RAM word starts as a mark of its own byte address
            ram[i] = 32'h5a5a_0000 ^ (i * 4);
        end
        // Upper immediates and OP-IMM, from 0x100
        rom[0]  = encU(20'h12345, 5'd1, opcLui);
        rom[1]  = encI(12'h678, 5'd1, 3'b000, 5'd1, opcImm);
        rom[2]  = encU(20'h00001, 5'd2, opcAuipc);
        rom[3]  = encI(12'hffb, 5'd0, 3'b000, 5'd3, opcImm);
        rom[4]  = encI(12'h007, 5'd0, 3'b000, 5'd4, opcImm);
        rom[5]  = encI(12'hffc, 5'd3, 3'b010, 5'd5, opcImm);
        rom[6]  = encI(12'h007, 5'd3, 3'b011, 5'd6, opcImm);
        rom[7]  = encI(12'h0f0, 5'd4, 3'b100, 5'd7, opcImm);
        rom[8]  = encI(12'h100, 5'd4, 3'b110, 5'd8, opcImm);
        rom[9]  = encI(12'h0ff, 5'd1, 3'b111, 5'd9, opcImm);
        rom[10] = encI(12'h004, 5'd4, 3'b001, 5'd10, opcImm);
        rom[11] = encI(12'h01c, 5'd3, 3'b101, 5'd11, opcImm);
        // SRAI, bit 30 set
        rom[12] = encI(12'h401, 5'd3, 3'b101, 5'd12, opcImm);
        // The ten OP forms
        rom[13] = encR(7'h00, 5'd4, 5'd3, 3'b000, 5'd13);
        rom[14] = encR(7'h20, 5'd3, 5'd4, 3'b000, 5'd14);
        rom[15] = encR(7'h00, 5'd4, 5'd4, 3'b001, 5'd15);
        rom[16] = encR(7'h00, 5'd4, 5'd3, 3'b010, 5'd16);
        rom[17] = encR(7'h00, 5'd4, 5'd3, 3'b011, 5'd17);
        rom[18] = encR(7'h00, 5'd3, 5'd1, 3'b100, 5'd18);
        rom[19] = encR(7'h00, 5'd4, 5'd3, 3'b101, 5'd19);
        rom[20] = encR(7'h20, 5'd4, 5'd3, 3'b101, 5'd20);
        rom[21] = encR(7'h00, 5'd10, 5'd4, 3'b110, 5'd21);
        rom[22] = encR(7'h00, 5'd7, 5'd1, 3'b111, 5'd22);
        // Stores then loads back, one with a negative offset
        rom[23] = encS(12'h010, 5'd1, 5'd0);
        rom[24] = encS(12'hff8, 5'd3, 5'd10);
        rom[25] = encI(12'h010, 5'd0, 3'b010, 5'd23, opcLoad);
        rom[26] = encI(12'hff8, 5'd10, 3'b010, 5'd24, opcLoad);
        // Write to x0, then read it back
        rom[27] = encI(12'h063, 5'd0, 3'b000, 5'd0, opcImm);
        rom[28] = encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd25);
        // Branch pairs, taken then not taken
        rom[29] = encB(13'd8, 5'd4, 5'd4, 3'b000);
        rom[31] = encB(13'd8, 5'd4, 5'd3, 3'b000);
        rom[32] = encB(13'd8, 5'd4, 5'd3, 3'b001);
        rom[34] = encB(13'd8, 5'd4, 5'd4, 3'b001);
        rom[35] = encB(13'd8, 5'd4, 5'd3, 3'b100);
        rom[37] = encB(13'd8, 5'd3, 5'd4, 3'b100);
        rom[38] = encB(13'd8, 5'd3, 5'd4, 3'b101);
        rom[40] = encB(13'd8, 5'd4, 5'd3, 3'b101);
        rom[41] = encB(13'd8, 5'd3, 5'd4, 3'b110);
        rom[43] = encB(13'd8, 5'd4, 5'd3, 3'b110);
        rom[44] = encB(13'd8, 5'd4, 5'd3, 3'b111);
        rom[46] = encB(13'd8, 5'd3, 5'd4, 3'b111);
        // JAL forward, JALR back with odd sum, JAL over the gap
        rom[47] = encJ(21'd12, 5'd27);
        rom[48] = encI(12'h044, 5'd0, 3'b000, 5'd28, opcImm);
        rom[49] = encJ(21'd12, 5'd0);
        rom[50] = encI(12'h001, 5'd27, 3'b000, 5'd29, opcJalr);
        rom[52] = encS(12'h018, 5'd29, 5'd0);
        // Final self loop
        rom[53] = encJ(21'd0, 5'd0);
    end

    // Zero-wait ROM, outside the program reads as no-op
    assign romOffset = instrAddr - romBase;
    assign instrData = (romOffset < 32'd256) ? rom[romOffset[7:2]] : 32'd0;

    // RAM covers bytes 0 to 255, other addresses echo an inverted address
    assign dataRdata = !dataRead ? 32'd0
                     : (dataAddr < 32'd256) ? ram[dataAddr[7:2]] : ~dataAddr;

    always @(posedge clk)
    begin
        if (dataWrite && (dataAddr < 32'd256))
            ram[dataAddr[7:2]] <= dataWdata;
    end

endmodule

// ==== rtl/rvCore.sv ====
// RV32I two-cycle core
`timescale 1ns/1ps

module rvCore import rvCorePkg::*; #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrData,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        dataWrite,
    output logic        dataRead,
    input  logic [31:0] dataRdata,
    output logic        wbValid,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData
);

    // Phase and redirect
    logic        executeStage;
    logic        fetchCapture;
    logic        branchTaken;
    logic [31:0] branchTarget;
    // Decoded fields and control
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  func3;
    logic [31:0] imm;
    aluOpT       aluCtrl;
    logic        aluSrcImm;
    logic        aluSrcPc;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        branch;
    logic        jump;
    logic        jumpReg;
    wbSelT       wbSel;
    // Register read data
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;

    // Instruction register loads during fetch
    assign fetchCapture = ~executeStage;

    instrFetch #(
        .resetVector (resetVector)
    ) u_fetch (
        .clk          (clk),
        .rst          (rst),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (instrAddr),
        .executeStage (executeStage)
    );

    decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .capture   (fetchCapture),
        .instrData (instrData),
        .rd        (wbReg),
        .rs1       (rs1),
        .rs2       (rs2),
        .func3     (func3),
        .imm       (imm),
        .aluCtrl   (aluCtrl),
        .aluSrcImm (aluSrcImm),
        .aluSrcPc  (aluSrcPc),
        .regWrite  (regWrite),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .branch    (branch),
        .jump      (jump),
        .jumpReg   (jumpReg),
        .wbSel     (wbSel)
    );

    // Write port doubles as the writeback trace
    regFile u_regFile (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (wbReg),
        .writeEn   (wbValid),
        .writeData (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    execute u_execute (
        .executeStage (executeStage),
        .pc           (instrAddr),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .imm          (imm),
        .func3        (func3),
        .aluCtrl      (aluCtrl),
        .aluSrcImm    (aluSrcImm),
        .aluSrcPc     (aluSrcPc),
        .regWrite     (regWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .branch       (branch),
        .jump         (jump),
        .jumpReg      (jumpReg),
        .wbSel        (wbSel),
        .dataRdata    (dataRdata),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataWrite    (dataWrite),
        .dataRead     (dataRead),
        .wbEnable     (wbValid),
        .wbData       (wbData)
    );

endmodule

// ==== rtl/execute.sv ====
// Execute and writeback stage
`timescale 1ns/1ps

module execute import rvCorePkg::*; (
    input  logic        executeStage,
    input  logic [31:0] pc,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    input  logic [31:0] imm,
    input  logic [2:0]  func3,
    input  aluOpT       aluCtrl,
    input  logic        aluSrcImm,
    input  logic        aluSrcPc,
    input  logic        regWrite,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic        branch,
    input  logic        jump,
    input  logic        jumpReg,
    input  wbSelT       wbSel,
    input  logic [31:0] dataRdata,
    output logic        branchTaken,
    output logic [31:0] branchTarget,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        dataWrite,
    output logic        dataRead,
    output logic        wbEnable,
    output logic [31:0] wbData
);

    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] pcPlus4;
    logic        condMet;

    // Operand muxes
    assign aluA = aluSrcPc ? pc : rs1Data;
    assign aluB = aluSrcImm ? imm : rs2Data;

    alu u_alu (
        .a      (aluA),
        .b      (aluB),
        .op     (aluCtrl),
        .result (aluResult)
    );

    // Branch condition by func3
    always_comb
    begin
        case (func3)
            3'b000:  condMet = (rs1Data == rs2Data);
            3'b001:  condMet = (rs1Data != rs2Data);
            3'b100:  condMet = ($signed(rs1Data) < $signed(rs2Data));
            3'b101:  condMet = ($signed(rs1Data) >= $signed(rs2Data));
            3'b110:  condMet = (rs1Data < rs2Data);
            3'b111:  condMet = (rs1Data >= rs2Data);
            default: condMet = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;

    // JALR clears bit 0 of the sum, others are pc relative
    assign branchTarget = jumpReg ? {aluResult[31:1], 1'b0} : pc + imm;
    assign branchTaken  = executeStage && (jump || jumpReg || (branch && condMet));

    // Word address from ALU sum, store data from rs2
    assign dataAddr  = aluResult;
    assign dataWdata = rs2Data;
    // Strobes live for the execute cycle only
    assign dataWrite = executeStage && memWrite;
    assign dataRead  = executeStage && memRead;
    assign wbEnable  = executeStage && regWrite;

    always_comb
    begin
        case (wbSel)
            wbMemData: wbData = dataRdata;
            wbPcPlus4: wbData = pcPlus4;
            default:   wbData = aluResult;
        endcase
    end

endmodule

// ==== rtl/regFile.sv ====
// Integer register file
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        writeEn,
    input  logic [31:0] writeData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    // Synchronous write, x0 never written
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= 32'd0;
            end
        end
        else if (writeEn && (rd != 5'd0))
        begin
            regs[rd] <= writeData;
        end
    end

    // Asynchronous read, x0 forced to zero
    assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// ==== rtl/decode.sv ====
// Instruction decode stage
`timescale 1ns/1ps

module decode import rvCorePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        capture,
    input  logic [31:0] instrData,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [2:0]  func3,
    output logic [31:0] imm,
    output aluOpT       aluCtrl,
    output logic        aluSrcImm,
    output logic        aluSrcPc,
    output logic        regWrite,
    output logic        memRead,
    output logic        memWrite,
    output logic        branch,
    output logic        jump,
    output logic        jumpReg,
    output wbSelT       wbSel
);

    logic [31:0] instrReg;
    logic [6:0]  opcode;
    logic [6:0]  func7;
    // Immediate forms, all sign extended
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // Word captured at end of fetch, zero after reset decodes as no-op
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            instrReg <= 32'd0;
        else if (capture)
            instrReg <= instrData;
    end

    // Field split
    assign opcode = instrReg[6:0];
    assign rd     = instrReg[11:7];
    assign func3  = instrReg[14:12];
    assign rs1    = instrReg[19:15];
    assign rs2    = instrReg[24:20];
    assign func7  = instrReg[31:25];

    assign immI = {{20{instrReg[31]}}, instrReg[31:20]};
    assign immS = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
    assign immB = {{19{instrReg[31]}}, instrReg[31], instrReg[7],
                   instrReg[30:25], instrReg[11:8], 1'b0};
    assign immU = {instrReg[31:12], 12'd0};
    assign immJ = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12],
                   instrReg[20], instrReg[30:21], 1'b0};

    // func3 to ALU op, alt picks SUB or SRA
    function automatic aluOpT mapFunc3(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb
    begin
        // Inactive defaults, left in place for unknown opcodes
        imm       = immI;
        aluCtrl   = aluAdd;
        aluSrcImm = 1'b0;
        aluSrcPc  = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        wbSel     = wbAluResult;
        case (opcode)
            opLui:
            begin
                imm       = immU;
                aluCtrl   = aluPassB;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opAuipc:
            begin
                imm       = immU;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                regWrite  = 1'b1;
            end
            opJal:
            begin
                // Target is pc plus imm, ALU idle
                imm      = immJ;
                jump     = 1'b1;
                regWrite = 1'b1;
                wbSel    = wbPcPlus4;
            end
            opJalr:
            begin
                // ALU sums rs1 and imm for the target
                aluSrcImm = 1'b1;
                jumpReg   = 1'b1;
                regWrite  = 1'b1;
                wbSel     = wbPcPlus4;
            end
            opBranch:
            begin
                imm    = immB;
                branch = 1'b1;
            end
            opLoad:
            begin
                // Word access only
                if (func3 == 3'b010)
                begin
                    aluSrcImm = 1'b1;
                    memRead   = 1'b1;
                    regWrite  = 1'b1;
                    wbSel     = wbMemData;
                end
            end
            opStore:
            begin
                if (func3 == 3'b010)
                begin
                    imm       = immS;
                    aluSrcImm = 1'b1;
                    memWrite  = 1'b1;
                end
            end
            opOpImm:
            begin
                // Bit 30 only matters for the right shift, ADDI has no SUB
                aluCtrl   = mapFunc3(func3, func7[5] && (func3 == 3'b101));
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opOp:
            begin
                aluCtrl  = mapFunc3(func3, func7[5]);
                regWrite = 1'b1;
            end
            default:
            begin
                // FENCE, SYSTEM and unknown words fall through as no-op
            end
        endcase
    end

endmodule

// ==== rtl/instrFetch.sv ====
// Program counter and phase control
`timescale 1ns/1ps

module instrFetch #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] pc,
    output logic        executeStage
);

    // Sequential next address
    logic [31:0] pcNext;

    assign pcNext = pc + 32'd4;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc           <= resetVector;
            // First cycle out of reset is a fetch
            executeStage <= 1'b0;
        end
        else
        begin
            // Fetch and execute alternate every cycle
            executeStage <= ~executeStage;
            // PC holds during fetch, advances at end of execute
            if (executeStage)
            begin
                pc <= branchTaken ? branchTarget : pcNext;
            end
        end
    end

endmodule

// ==== rtl/alu.sv ====
// 32-bit integer ALU
`timescale 1ns/1ps

module alu import rvCorePkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOpT       op,
    output logic [31:0] result
);

    // Shift amount from low five bits
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << shamt;
            // Signed compare
            aluSlt:   result = {31'd0, $signed(a) < $signed(b)};
            aluSltu:  result = {31'd0, a < b};
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> shamt;
            // Arithmetic shift keeps the sign
            aluSra:   result = $unsigned($signed(a) >>> shamt);
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluPassB: result = b;
            default:  result = 32'd0;
        endcase
    end

endmodule

// ==== rtl/rvCorePkg.sv ====
// RV32I core shared definitions
package rvCorePkg;

    // Major opcodes, instruction bits 6:0
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    // ALU operation select
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        // Operand B straight through, used by LUI
        aluPassB = 4'd10
    } aluOpT;

    // Register writeback source
    typedef enum logic [1:0] {
        wbAluResult = 2'd0,
        wbMemData   = 2'd1,
        // Link address for JAL and JALR
        wbPcPlus4   = 2'd2
    } wbSelT;

endpackage
